/* compile.f */
source/lock_pkg.sv
source/key_decoder.sv
source/code_entry.sv
source/lockout_timer.sv
source/buzzer_ctrl.sv
source/lock_top.sv
test/lock_assert.sv
test/lock_checker.sv
test/lock_tb.sv

/* run.sh */
#!/bin/sh
# build and run the lock testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lock_tb -f compile.f -o lock_sim
./obj_dir/lock_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

/* test/lock_tb.sv */
`timescale 1ns/1ps

module lock_tb;
    import lock_pkg::*;

    localparam int CPM = 4;

    logic        clk;
    logic        rst;
    logic [15:0] keys;
    display_t    display;
    tries_t      tries;
    logic        unlocked;
    logic        lockout;
    logic        buzzer;

    // model state: 0 entry, 1 unlocked, 2 lockout, 3 expired
    int       m_state;
    int       m_cnt;
    display_t m_disp;
    tries_t   m_tries;

    lock_top #(.cycles_per_ms(CPM)) i_dut (
        .clk      (clk),
        .rst      (rst),
        .keys     (keys),
        .display  (display),
        .tries    (tries),
        .unlocked (unlocked),
        .lockout  (lockout),
        .buzzer   (buzzer)
    );

    lock_checker #(.cycles_per_ms(CPM)) i_checker (
        .clk      (clk),
        .display  (display),
        .tries    (tries),
        .unlocked (unlocked),
        .lockout  (lockout),
        .buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int digit_bit(input int d);
        case (d)
            1: return KEY_BIT_D1;
            2: return KEY_BIT_D2;
            3: return KEY_BIT_D3;
            4: return KEY_BIT_D4;
            5: return KEY_BIT_D5;
            6: return KEY_BIT_D6;
            7: return KEY_BIT_D7;
            8: return KEY_BIT_D8;
            default: return KEY_BIT_D9;
        endcase
    endfunction

    // reference model, returns the tone the key should play
    function automatic int model_key(input key_kind_t kind, input int d);
        tries_t next_tries;
        int     tone;
        next_tries = m_tries + 2'd1;
        tone = (m_state == 2) ? 0 : 1;  // keys dead during countdown
        if (m_state == 0) begin
            case (kind)
                KEY_DIGIT: if (m_cnt < 3) begin
                    m_disp = {m_disp[7:0], 4'(d)};
                    m_cnt++;
                end
                KEY_CLEAR_ENTRY: begin
                    m_disp = BLANK_DISPLAY;
                    m_cnt  = 0;
                end
                KEY_CLEAR_ALL: begin
                    m_disp  = BLANK_DISPLAY;
                    m_cnt   = 0;
                    m_tries = '0;
                end
                default: if (m_cnt == 3) begin
                    m_cnt = 0;
                    if (m_disp == SECRET_CODE) begin
                        m_state = 1;
                        m_disp  = PASS_DISPLAY;
                        tone    = 2;
                    end else begin
                        tone = 3;
                        if (next_tries == MAX_TRIES) begin
                            m_state = 2;
                            m_tries = '0;
                            m_disp  = {4'h0, LOCKOUT_SECONDS};
                        end else begin
                            m_disp  = BLANK_DISPLAY;
                            m_tries = next_tries;
                        end
                    end
                end
            endcase
        end else if (m_state != 2 && kind == KEY_CLEAR_ALL) begin
            m_state = 0;
            m_disp  = BLANK_DISPLAY;
            m_cnt   = 0;
            m_tries = '0;
        end
        return tone;
    endfunction

    // one second less, through the decimal value
    function automatic logic [7:0] bcd_down(input logic [7:0] v);
        int n;
        n = 10 * int'(v[7:4]) + int'(v[3:0]) - 1;
        return {4'(n / 10), 4'(n % 10)};
    endfunction

    task automatic press(input key_kind_t kind, input int d);
        int bitn;
        int tone;
        case (kind)
            KEY_DIGIT:       bitn = digit_bit(d);
            KEY_ENTER:       bitn = KEY_BIT_ENTER;
            KEY_CLEAR_ENTRY: bitn = KEY_BIT_CLEAR_ENTRY;
            default:         bitn = KEY_BIT_CLEAR_ALL;
        endcase
        @(posedge clk);
        #1 keys = 16'h1 << bitn;
        i_checker.arm();
        repeat (3) @(posedge clk);
        #1 keys = '0;
        tone = model_key(kind, d);
        i_checker.verify_outputs(m_disp, m_tries, m_state == 1, m_state >= 2);
        i_checker.listen_for_tone(tone);
    endtask

    task automatic enter_wrong_code();
        int d0;
        int d1;
        int d2;
        do begin
            d0 = 1 + int'($urandom % 9);
            d1 = 1 + int'($urandom % 9);
            d2 = 1 + int'($urandom % 9);
        end while (d0 == 2 && d1 == 4 && d2 == 6);
        press(KEY_DIGIT, d0);
        press(KEY_DIGIT, d1);
        press(KEY_DIGIT, d2);
        press(KEY_ENTER, 0);
    endtask

    initial begin
        logic [7:0] count;
        int         period;
        int         assert_fails;
        keys    = '0;
        rst     = 1'b1;
        m_state = 0;
        m_cnt   = 0;
        m_disp  = BLANK_DISPLAY;
        m_tries = '0;
        void'($urandom(32'ha9be));
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        i_checker.arm();
        i_checker.verify_outputs(m_disp, m_tries, 1'b0, 1'b0);
        i_checker.listen_for_tone(0);

        repeat (3) begin  // random digits, overflow and clear-entry
            press(KEY_CLEAR_ALL, 0);
            repeat (6) begin
                if ($urandom % 5 == 0) press(KEY_CLEAR_ENTRY, 0);
                else press(KEY_DIGIT, 1 + int'($urandom % 9));
            end
        end
        press(KEY_CLEAR_ENTRY, 0);

        press(KEY_DIGIT, 2);
        press(KEY_DIGIT, 4);
        press(KEY_DIGIT, 6);
        press(KEY_ENTER, 0);
        press(KEY_DIGIT, 5);
        press(KEY_CLEAR_ALL, 0);

        enter_wrong_code();
        press(KEY_DIGIT, 1 + int'($urandom % 9));
        press(KEY_DIGIT, 1 + int'($urandom % 9));
        press(KEY_ENTER, 0);  // short entry, nothing happens
        press(KEY_CLEAR_ENTRY, 0);
        enter_wrong_code();
        enter_wrong_code();   // third fail starts the lockout

        count = LOCKOUT_SECONDS;
        for (int i = 0; i < 20; i++) begin
            i_checker.wait_display_change(period);
            if (i > 0) i_checker.report_mismatch("countdown period", 32'(period), 32'(1000 * CPM));
            count  = bcd_down(count);
            m_disp = {4'h0, count};
            if (count == 8'h00) m_state = 3;
            press(KEY_DIGIT, 1 + int'($urandom % 9));
        end
        press(KEY_ENTER, 0);
        press(KEY_CLEAR_ENTRY, 0);
        press(KEY_CLEAR_ALL, 0);

        assert_fails = i_dut.i_code_entry.i_lock_assert.fail_count;
        $display("check errors: %0d, assertion errors: %0d", i_checker.errors, assert_fails);
        if (i_checker.errors == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* test/lock_checker.sv */
`timescale 1ns/1ps

module lock_checker #(
    parameter int cycles_per_ms = 4
) (
    input logic               clk,
    input lock_pkg::display_t display,
    input lock_pkg::tries_t   tries,
    input logic               unlocked,
    input logic               lockout,
    input logic               buzzer
);
    import lock_pkg::*;

    int   errors = 0;
    int   cycle_cnt = 0;
    int   toggle_cnt = 0;
    logic buzzer_q = 1'b0;
    int   arm_cycle = 0;
    int   arm_toggles = 0;
    int   last_change = 0;

    // free counters, sampled on the falling edge where outputs are stable
    always @(negedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (buzzer !== buzzer_q) begin
            toggle_cnt <= toggle_cnt + 1;
        end
        buzzer_q <= buzzer;
    end

    task automatic fail(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] act,
                                   input logic [31:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, act, exp);
            errors++;
        end
    endtask

    task automatic arm();
        arm_cycle   = cycle_cnt;
        arm_toggles = toggle_cnt;
    endtask

    task automatic verify_outputs(input display_t exp_disp, input tries_t exp_tries,
                                  input logic exp_unlocked, input logic exp_lockout);
        repeat (3) @(negedge clk);
        report_mismatch("display", 32'(display), 32'(exp_disp));
        report_mismatch("tries", 32'(tries), 32'(exp_tries));
        report_mismatch("unlocked", 32'(unlocked), 32'(exp_unlocked));
        report_mismatch("lockout", 32'(lockout), 32'(exp_lockout));
    endtask

    // tone: 0 none, 1 click, 2 success, 3 fail
    task automatic listen_for_tone(input int tone);
        int   dur_ms;
        int   limit;
        int   waited;
        logic loud;
        loud = 1'b0;
        if (tone != 0) begin
            dur_ms = (tone == 1) ? CLICK_MS : (tone == 2) ? SUCCESS_MS : FAIL_MS;
            waited = 0;
            while (toggle_cnt - arm_toggles < 2 && waited < 40) begin
                @(negedge clk);
                waited++;
            end
            if (toggle_cnt - arm_toggles < 2) begin
                fail("buzzer never toggled after a key");
            end
            limit  = dur_ms * cycles_per_ms + 10;
            waited = 0;
            while (cycle_cnt - arm_cycle < limit && waited < limit) begin
                @(negedge clk);
                waited++;
            end
        end
        repeat (20) begin
            @(negedge clk);
            loud = loud | buzzer;
        end
        report_mismatch("buzzer", 32'(loud), 32'h0);  // silent once the tone is over
    endtask

    task automatic wait_display_change(output int period);
        display_t start;
        int       waited;
        start  = display;
        waited = 0;
        while (display === start && waited < 4100) begin
            @(negedge clk);
            waited++;
        end
        if (display === start) begin
            fail("display did not count down within 4100 cycles");
        end
        period      = cycle_cnt - last_change;
        last_change = cycle_cnt;
    endtask

endmodule

/* test/lock_assert.sv */
`timescale 1ns/1ps

module lock_assert (
    input logic               clk,
    input logic               rst,
    input logic               accepted,
    input logic               tone_start,
    input lock_pkg::tone_t    tone_sel,
    input logic               unlocked,
    input logic               lockout,
    input logic               lockout_start,
    input lock_pkg::display_t display,
    input lock_pkg::tries_t   tries
);
    import lock_pkg::*;

    int fail_count = 0;

    function automatic logic nibbles_ok(input display_t d);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (d[i*4 +: 4] > 4'd9 && d[i*4 +: 4] != BLANK_DIGIT) begin
                ok = 1'b0;
            end
        end
        return ok || (d == PASS_DISPLAY);  // pass pattern uses B and C
    endfunction

    // success tone exactly when the lock opens
    a_tone_follows_key: assert property (@(posedge clk) disable iff (rst)
        accepted |=> tone_start
            && ((tone_sel == TONE_SUCCESS) == (unlocked && !$past(unlocked))))
        else begin
            $error("tone_start missing or wrong tone after an accepted key");
            fail_count++;
        end

    a_display_digits: assert property (@(posedge clk) disable iff (rst)
        nibbles_ok(display))
        else begin
            $error("display holds a nibble that is neither bcd nor blank");
            fail_count++;
        end

    a_lockout_on_third_fail: assert property (@(posedge clk) disable iff (rst)
        lockout_start |-> $rose(lockout) && tries == 2'd0 && $past(tries) == MAX_TRIES - 2'd1
            && display == {4'h0, LOCKOUT_SECONDS})
        else begin
            $error("lockout_start without a third failed try");
            fail_count++;
        end

endmodule

bind code_entry lock_assert i_lock_assert (
    .clk           (clk),
    .rst           (rst),
    .accepted      (accepted),
    .tone_start    (tone_start),
    .tone_sel      (tone_sel),
    .unlocked      (unlocked),
    .lockout       (lockout),
    .lockout_start (lockout_start),
    .display       (display),
    .tries         (tries)
);

/* source/lock_top.sv */
`timescale 1ns/1ps

module lock_top #(
    parameter int cycles_per_ms = 50000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        keys,
    output lock_pkg::display_t display,
    output lock_pkg::tries_t   tries,
    output logic               unlocked,
    output logic               lockout,
    output logic               buzzer
);
    import lock_pkg::*;

    logic       key_valid;
    key_kind_t  key_kind;
    bcd_digit_t key_digit;
    logic       tone_start;
    tone_t      tone_sel;
    logic       lockout_start;
    logic       lockout_done;
    logic [7:0] lockout_count;
    logic       ms_tick;

    key_decoder i_key_decoder (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .key_valid (key_valid),
        .key_kind  (key_kind),
        .key_digit (key_digit)
    );

    code_entry i_code_entry (
        .clk           (clk),
        .rst           (rst),
        .key_valid     (key_valid),
        .key_kind      (key_kind),
        .key_digit     (key_digit),
        .lockout_count (lockout_count),
        .lockout_done  (lockout_done),
        .display       (display),
        .tries         (tries),
        .unlocked      (unlocked),
        .lockout       (lockout),
        .tone_start    (tone_start),
        .tone_sel      (tone_sel),
        .lockout_start (lockout_start)
    );

    lockout_timer #(
        .cycles_per_ms (cycles_per_ms)
    ) i_lockout_timer (
        .clk           (clk),
        .rst           (rst),
        .lockout_start (lockout_start),
        .ms_tick       (ms_tick),
        .lockout_count (lockout_count),
        .lockout_done  (lockout_done)
    );

    buzzer_ctrl #(
        .cycles_per_ms (cycles_per_ms)
    ) i_buzzer_ctrl (
        .clk        (clk),
        .rst        (rst),
        .ms_tick    (ms_tick),
        .tone_start (tone_start),
        .tone_sel   (tone_sel),
        .buzzer     (buzzer)
    );

endmodule

/* source/buzzer_ctrl.sv */
`timescale 1ns/1ps

module buzzer_ctrl #(
    parameter int cycles_per_ms = 50000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            ms_tick,
    input  logic            tone_start,
    input  lock_pkg::tone_t tone_sel,
    output logic            buzzer
);
    import lock_pkg::*;

    // half-periods in cycles, never below one
    localparam int HALF_HIGH = (cycles_per_ms >= PITCH_HIGH) ? cycles_per_ms / PITCH_HIGH : 1;
    localparam int HALF_MID  = (cycles_per_ms >= PITCH_MID) ? cycles_per_ms / PITCH_MID : 1;
    localparam int HALF_LOW  = (cycles_per_ms >= PITCH_LOW) ? cycles_per_ms / PITCH_LOW : 1;
    localparam int HALF_W    = $clog2(cycles_per_ms + 1);
    localparam int DUR_W     = $clog2(SUCCESS_MS + 1);  // longest tone
    localparam int GAP_START = FAIL_MS / 3;
    localparam int GAP_END   = 2 * FAIL_MS / 3;

    tone_t             sel_q;
    logic              active;
    logic              wave;
    logic [HALF_W-1:0] half_cnt;
    logic [HALF_W-1:0] half_len;
    logic [DUR_W-1:0]  dur_cnt;    // elapsed ms ticks
    logic [DUR_W-1:0]  dur_len;
    logic              gap;

    always_comb begin
        case (sel_q)
            TONE_SUCCESS: begin
                half_len = HALF_W'(HALF_HIGH);
                dur_len  = DUR_W'(SUCCESS_MS);
            end
            TONE_FAIL: begin
                half_len = HALF_W'(HALF_LOW);
                dur_len  = DUR_W'(FAIL_MS);
            end
            default: begin  // key click
                half_len = HALF_W'(HALF_MID);
                dur_len  = DUR_W'(CLICK_MS);
            end
        endcase
    end

    // fail tone is broken in its middle third
    assign gap    = (sel_q == TONE_FAIL) && (dur_cnt >= DUR_W'(GAP_START))
                    && (dur_cnt < DUR_W'(GAP_END));
    assign buzzer = active && wave && !gap;

    always_ff @(posedge clk) begin
        if (tone_start) begin
            sel_q <= tone_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            wave     <= 1'b0;
            half_cnt <= '0;
            dur_cnt  <= '0;
        end else if (tone_start) begin  // restart even mid-tone
            active   <= 1'b1;
            wave     <= 1'b1;
            half_cnt <= '0;
            dur_cnt  <= '0;
        end else if (active) begin
            if (half_cnt == half_len - 1'b1) begin
                half_cnt <= '0;
                wave     <= ~wave;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            if (ms_tick) begin
                if (dur_cnt == dur_len - 1'b1) begin
                    active <= 1'b0;
                    wave   <= 1'b0;
                end else begin
                    dur_cnt <= dur_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* source/lockout_timer.sv */
`timescale 1ns/1ps

module lockout_timer #(
    parameter int cycles_per_ms = 50000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       lockout_start,
    output logic       ms_tick,
    output logic [7:0] lockout_count,
    output logic       lockout_done
);
    import lock_pkg::*;

    localparam int PRE_W = $clog2(cycles_per_ms + 1);
    localparam int SEC_W = $clog2(MS_PER_SECOND);

    logic [PRE_W-1:0] pre_cnt;    // cycles within one ms
    logic [SEC_W-1:0] ms_cnt;     // ms within one second
    logic             running;
    logic [7:0]       count_dec;

    // free-running ms prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt <= '0;
            ms_tick <= 1'b0;
        end else if (pre_cnt == PRE_W'(cycles_per_ms - 1)) begin
            pre_cnt <= '0;
            ms_tick <= 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            ms_tick <= 1'b0;
        end
    end

    // bcd step down, borrow from the tens
    always_comb begin
        if (lockout_count[3:0] == 4'd0) begin
            count_dec = {lockout_count[7:4] - 4'd1, 4'd9};
        end else begin
            count_dec = {lockout_count[7:4], lockout_count[3:0] - 4'd1};
        end
    end

    always_ff @(posedge clk) begin
        lockout_done <= 1'b0;
        if (rst) begin
            running       <= 1'b0;
            ms_cnt        <= '0;
            lockout_count <= '0;
        end else if (lockout_start) begin
            running       <= 1'b1;
            ms_cnt        <= '0;  // full first second
            lockout_count <= LOCKOUT_SECONDS;
        end else if (running && ms_tick) begin
            if (ms_cnt == SEC_W'(MS_PER_SECOND - 1)) begin
                ms_cnt        <= '0;
                lockout_count <= count_dec;
                if (lockout_count == 8'h01) begin  // reaching 00, hold there
                    running      <= 1'b0;
                    lockout_done <= 1'b1;
                end
            end else begin
                ms_cnt <= ms_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/code_entry.sv */
`timescale 1ns/1ps

module code_entry (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_valid,
    input  lock_pkg::key_kind_t   key_kind,
    input  lock_pkg::bcd_digit_t  key_digit,
    input  logic [7:0]            lockout_count,
    input  logic                  lockout_done,
    output lock_pkg::display_t    display,
    output lock_pkg::tries_t      tries,
    output logic                  unlocked,
    output logic                  lockout,
    output logic                  tone_start,
    output lock_pkg::tone_t       tone_sel,
    output logic                  lockout_start
);
    import lock_pkg::*;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_UNLOCKED,
        ST_LOCKOUT,
        ST_EXPIRED
    } entry_state_t;

    entry_state_t state;
    display_t     entry_q;     // digits as shown outside lockout
    logic [1:0]   digit_cnt;
    tries_t       tries_inc;
    logic         accepted;
    logic         enter_full;
    logic         code_match;

    assign accepted   = key_valid && (state != ST_LOCKOUT);  // keys dead during countdown
    assign enter_full = key_valid && (state == ST_ENTRY) && (key_kind == KEY_ENTER)
                        && (digit_cnt == 2'd3);
    assign code_match = (entry_q == SECRET_CODE);
    assign tries_inc  = tries + 2'd1;

    always_ff @(posedge clk) begin
        tone_start    <= accepted;
        lockout_start <= 1'b0;
        if (rst) begin
            state         <= ST_ENTRY;
            entry_q       <= BLANK_DISPLAY;
            digit_cnt     <= '0;
            tries         <= '0;
            tone_start    <= 1'b0;
        end else begin
            case (state)
                ST_ENTRY: begin
                    if (key_valid) begin
                        case (key_kind)
                            KEY_DIGIT: begin
                                if (digit_cnt < 2'd3) begin  // fourth digit dropped
                                    entry_q   <= {entry_q[7:0], key_digit};
                                    digit_cnt <= digit_cnt + 2'd1;
                                end
                            end
                            KEY_CLEAR_ENTRY: begin
                                entry_q   <= BLANK_DISPLAY;
                                digit_cnt <= '0;
                            end
                            KEY_CLEAR_ALL: begin
                                entry_q   <= BLANK_DISPLAY;
                                digit_cnt <= '0;
                                tries     <= '0;
                            end
                            default: begin
                                if (enter_full) begin
                                    digit_cnt <= '0;
                                    if (code_match) begin
                                        state   <= ST_UNLOCKED;
                                        entry_q <= PASS_DISPLAY;
                                    end else if (tries_inc == MAX_TRIES) begin
                                        state         <= ST_LOCKOUT;
                                        entry_q       <= BLANK_DISPLAY;
                                        tries         <= '0;
                                        lockout_start <= 1'b1;
                                    end else begin
                                        entry_q <= BLANK_DISPLAY;
                                        tries   <= tries_inc;
                                    end
                                end
                            end
                        endcase
                    end
                end
                ST_LOCKOUT: begin
                    if (lockout_done) begin
                        state   <= ST_EXPIRED;
                        entry_q <= 12'h000;
                    end
                end
                default: begin  // unlocked or expired, only clear-all counts
                    if (key_valid && key_kind == KEY_CLEAR_ALL) begin
                        state     <= ST_ENTRY;
                        entry_q   <= BLANK_DISPLAY;
                        digit_cnt <= '0;
                        tries     <= '0;
                    end
                end
            endcase
        end
    end

    // tone choice rides along with tone_start
    always_ff @(posedge clk) begin
        if (enter_full) begin
            tone_sel <= code_match ? TONE_SUCCESS : TONE_FAIL;
        end else if (key_valid) begin
            tone_sel <= TONE_CLICK;
        end
    end

    always_comb begin
        if (state != ST_LOCKOUT) begin
            display = entry_q;
        end else if (lockout_start) begin
            display = {4'h0, LOCKOUT_SECONDS};  // count not loaded yet
        end else begin
            display = {4'h0, lockout_count};
        end
    end

    assign unlocked = (state == ST_UNLOCKED);
    assign lockout  = (state == ST_LOCKOUT) || (state == ST_EXPIRED);

endmodule

/* source/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [15:0]           keys,
    output logic                  key_valid,
    output lock_pkg::key_kind_t   key_kind,
    output lock_pkg::bcd_digit_t  key_digit
);
    import lock_pkg::*;

    logic [15:0] keys_cur;     // sampled keypad word
    logic [15:0] keys_prev;    // sample from the cycle before
    logic        mapped;
    key_kind_t   dec_kind;
    bcd_digit_t  dec_digit;

    always_comb begin
        mapped    = 1'b1;
        dec_kind  = KEY_DIGIT;
        dec_digit = BLANK_DIGIT;
        case (keys_cur)
            16'h1 << KEY_BIT_ENTER:       dec_kind = KEY_ENTER;
            16'h1 << KEY_BIT_CLEAR_ALL:   dec_kind = KEY_CLEAR_ALL;
            16'h1 << KEY_BIT_CLEAR_ENTRY: dec_kind = KEY_CLEAR_ENTRY;
            16'h1 << KEY_BIT_D1:          dec_digit = 4'd1;
            16'h1 << KEY_BIT_D2:          dec_digit = 4'd2;
            16'h1 << KEY_BIT_D3:          dec_digit = 4'd3;
            16'h1 << KEY_BIT_D4:          dec_digit = 4'd4;
            16'h1 << KEY_BIT_D5:          dec_digit = 4'd5;
            16'h1 << KEY_BIT_D6:          dec_digit = 4'd6;
            16'h1 << KEY_BIT_D7:          dec_digit = 4'd7;
            16'h1 << KEY_BIT_D8:          dec_digit = 4'd8;
            16'h1 << KEY_BIT_D9:          dec_digit = 4'd9;
            default:                      mapped = 1'b0;  // release, unmapped or multi-key
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            keys_cur  <= '0;
            keys_prev <= '0;
            key_valid <= 1'b0;
        end else begin
            keys_cur  <= keys;
            keys_prev <= keys_cur;
            key_valid <= mapped && (keys_cur != keys_prev);  // once per new key
        end
    end

    always_ff @(posedge clk) begin
        key_kind  <= dec_kind;
        key_digit <= dec_digit;
    end

endmodule

/* source/lock_pkg.sv */
package lock_pkg;

    typedef logic [3:0]  bcd_digit_t;
    typedef logic [11:0] display_t;    // three bcd nibbles, msd first
    typedef logic [1:0]  tries_t;

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_ENTER,
        KEY_CLEAR_ENTRY,
        KEY_CLEAR_ALL
    } key_kind_t;

    typedef enum logic [1:0] {
        TONE_CLICK,
        TONE_SUCCESS,
        TONE_FAIL
    } tone_t;

    localparam bcd_digit_t BLANK_DIGIT   = 4'hF;
    localparam display_t   BLANK_DISPLAY = 12'hFFF;
    localparam display_t   PASS_DISPLAY  = 12'hBCC;
    localparam display_t   SECRET_CODE   = 12'h246;

    localparam tries_t     MAX_TRIES       = 2'd3;
    localparam logic [7:0] LOCKOUT_SECONDS = 8'h20;   // bcd

    // bit positions in the one-hot keypad word
    localparam int KEY_BIT_ENTER       = 0;
    localparam int KEY_BIT_D3          = 5;
    localparam int KEY_BIT_D2          = 6;
    localparam int KEY_BIT_D1          = 7;
    localparam int KEY_BIT_CLEAR_ALL   = 8;
    localparam int KEY_BIT_D6          = 9;
    localparam int KEY_BIT_D5          = 10;
    localparam int KEY_BIT_D4          = 11;
    localparam int KEY_BIT_CLEAR_ENTRY = 12;
    localparam int KEY_BIT_D9          = 13;
    localparam int KEY_BIT_D8          = 14;
    localparam int KEY_BIT_D7          = 15;

    localparam int CLICK_MS   = 200;
    localparam int SUCCESS_MS = 600;
    localparam int FAIL_MS    = 300;

    localparam int PITCH_HIGH = 4;
    localparam int PITCH_MID  = 2;
    localparam int PITCH_LOW  = 1;

    localparam int MS_PER_SECOND = 1000;

endpackage
